//--- board_pkg.sv
package board_pkg;

    // APB data and address widths
    localparam int data_w = 32;
    localparam int addr_w = 5;

    // Interrupt vector and software LED widths
    localparam int irq_w = 8;
    localparam int led_w = 5;

    // Register byte offsets
    localparam logic [addr_w-1:0] reg_status  = 5'h00;
    localparam logic [addr_w-1:0] reg_pending = 5'h04;
    localparam logic [addr_w-1:0] reg_mask    = 5'h08;
    localparam logic [addr_w-1:0] reg_active  = 5'h0C;
    localparam logic [addr_w-1:0] reg_led     = 5'h10;

    // Interrupt bit positions, bit 0 wins
    localparam int irq_uart  = 0;
    localparam int irq_ost1  = 1;
    localparam int irq_ost2  = 2;
    localparam int irq_ost3  = 3;
    localparam int irq_frame = 4;

    // Named interrupt sources, MSB first
    typedef struct packed {
        // Spare bits above frame, always zero
        logic [irq_w-irq_frame-2:0] spare;
        logic                       frame;
        logic                       ost3;
        logic                       ost2;
        logic                       ost1;
        logic                       uart;
    } irq_src_t;

    // Same word seen as a flat vector or as named sources
    typedef union packed {
        logic [irq_w-1:0] vec;
        irq_src_t         fld;
    } irq_word_t;

endpackage

//--- reset_gen.sv
`timescale 1ns/1ns

module reset_gen #(
    parameter int DTR_RESET_CYCLES = 16
) (
    input  logic clk100,
    input  logic rst,
    input  logic reset_n,
    input  logic uart_dtr_n,
    output logic cpu_rst,
    output logic sys_rst
);

    // Counter wide enough to hold the full DTR hold time
    localparam int cnt_w = $clog2(DTR_RESET_CYCLES + 1);

    // Button synchronizer, high while pressed
    logic [1:0]       btn_sync;
    // Two DTR sync stages, then one delay stage for edge detect
    logic [2:0]       dtr_sync;
    logic             dtr_fall;
    logic [cnt_w-1:0] dtr_cnt;

    always_ff @(posedge clk100)
    begin
        if (rst)
        begin
            btn_sync <= 2'b00;
            // DTR idles high, so no false edge after reset
            dtr_sync <= 3'b111;
            dtr_fall <= 1'b0;
            dtr_cnt  <= '0;
        end
        else
        begin
            btn_sync <= {btn_sync[0], ~reset_n};
            dtr_sync <= {dtr_sync[1:0], uart_dtr_n};
            // Registered falling edge of the synchronized DTR
            dtr_fall <= dtr_sync[2] & ~dtr_sync[1];
            // A new edge restarts the hold time
            if (dtr_fall)
                dtr_cnt <= cnt_w'(DTR_RESET_CYCLES);
            else if (dtr_cnt != '0)
                dtr_cnt <= dtr_cnt - 1'b1;
        end
    end

    // Any reset source holds the CPU in reset
    assign cpu_rst = rst | btn_sync[1] | (dtr_cnt != '0);
    assign sys_rst = cpu_rst;

    a_rst_forces_cpu_rst: assert property (@(posedge clk100) rst |-> cpu_rst)
        else $error("cpu_rst low while rst is high");

    // DTR edge holds reset for the whole programmed window
    a_dtr_hold: assert property (@(posedge clk100) disable iff (rst)
        dtr_fall |=> cpu_rst [*DTR_RESET_CYCLES])
        else $error("DTR reset window too short");

endmodule

//--- board_inputs.sv
`timescale 1ns/1ns

module board_inputs (
    input  logic       clk100,
    input  logic       sys_rst,
    input  logic [3:0] dipsw,
    input  logic       frame_drawn,
    output logic       boot_mode,
    output logic       half_res,
    output logic       frame_pulse
);

    // Only switches 3 and 2 carry a function, rightmost is dipsw[0]
    logic [1:0] sw_s1;
    logic [1:0] sw_s2;
    // Frame-drawn sync stages plus edge delay
    logic       fd_s1;
    logic       fd_s2;
    logic       fd_d;

    // Static switches, two plain sync stages
    always_ff @(posedge clk100)
    begin
        sw_s1 <= dipsw[3:2];
        sw_s2 <= sw_s1;
    end

    assign boot_mode = sw_s2[1];
    assign half_res  = sw_s2[0];

    // Frame-drawn crosses from the pixel clock domain
    always_ff @(posedge clk100)
    begin
        if (sys_rst)
        begin
            fd_s1       <= 1'b0;
            fd_s2       <= 1'b0;
            fd_d        <= 1'b0;
            frame_pulse <= 1'b0;
        end
        else
        begin
            fd_s1       <= frame_drawn;
            fd_s2       <= fd_s1;
            fd_d        <= fd_s2;
            // One-cycle pulse on the synchronized rising edge
            frame_pulse <= fd_s2 & ~fd_d;
        end
    end

    a_frame_pulse_single: assert property (@(posedge clk100) disable iff (sys_rst)
        frame_pulse |=> !frame_pulse)
        else $error("frame_pulse wider than one cycle");

endmodule

//--- irq_ctrl.sv
`timescale 1ns/1ns

module irq_ctrl (
    input  logic                 clk100,
    input  logic                 sys_rst,
    input  logic                 uart_irq,
    input  logic                 ost1_int,
    input  logic                 ost2_int,
    input  logic                 ost3_int,
    input  logic                 frame_pulse,
    input  board_pkg::irq_word_t mask,
    input  board_pkg::irq_word_t clear_req,
    output board_pkg::irq_word_t pending,
    output board_pkg::irq_word_t irq_vec,
    output logic                 irq,
    output logic                 active_valid,
    output logic [2:0]           active_idx
);

    import board_pkg::*;

    // Raw sources in interrupt bit order
    irq_word_t src_word;

    always_comb
    begin
        src_word           = '0;
        src_word.fld.uart  = uart_irq;
        src_word.fld.ost1  = ost1_int;
        src_word.fld.ost2  = ost2_int;
        src_word.fld.ost3  = ost3_int;
        src_word.fld.frame = frame_pulse;
    end

    // Pending latches
    // A source still high re-sets its bit, so set beats clear
    always_ff @(posedge clk100)
    begin
        if (sys_rst)
        begin
            pending <= '0;
        end
        else
        begin
            pending.vec <= (pending.vec & ~clear_req.vec) | src_word.vec;
        end
    end

    // Masked vector follows pending without delay
    assign irq_vec.vec  = pending.vec & mask.vec;
    assign irq          = |irq_vec.vec;
    assign active_valid = irq;

    // Lowest set index wins, so scan from the top down
    always_comb
    begin
        active_idx = '0;
        for (int i = irq_w - 1; i >= 0; i--)
        begin
            if (irq_vec.vec[i])
            begin
                active_idx = 3'(i);
            end
        end
    end

    a_irq_has_source: assert property (@(posedge clk100) disable iff (sys_rst)
        irq |-> (irq_vec.vec != '0))
        else $error("irq high with empty vector");

    // Nothing ever sets the spare positions
    a_spare_zero: assert property (@(posedge clk100) disable iff (sys_rst)
        pending.fld.spare == '0)
        else $error("spare pending bits set");

    // A masked-in source raises irq on the cycle after it is seen
    a_src_to_irq: assert property (@(posedge clk100) disable iff (sys_rst)
        ((src_word.vec & mask.vec) != '0) ##1 $stable(mask) |-> irq)
        else $error("enabled source did not raise irq");

endmodule

//--- apb_regs.sv
`timescale 1ns/1ns

module apb_regs (
    input  logic                         clk100,
    input  logic                         sys_rst,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [board_pkg::addr_w-1:0] paddr,
    input  logic [board_pkg::data_w-1:0] pwdata,
    output logic [board_pkg::data_w-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic                         boot_mode,
    input  logic                         half_res,
    input  board_pkg::irq_word_t         pending,
    input  logic                         active_valid,
    input  logic [2:0]                   active_idx,
    output board_pkg::irq_word_t         mask,
    output board_pkg::irq_word_t         clear_req,
    output logic                         led_gpu,
    output logic                         led_flash,
    output logic                         led_usb,
    output logic                         led_eth,
    output logic                         led_user
);

    import board_pkg::*;

    logic             access;
    logic             wr_en;
    logic             addr_ok;
    logic [data_w-1:0] rd_data;
    logic [led_w-1:0] led_q;

    // Access phase of a transfer
    assign access = psel & penable;
    assign wr_en  = access & pwrite;

    // No wait states
    assign pready = 1'b1;

    // Offset decode and read mux
    always_comb
    begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (paddr)
            reg_status:
                rd_data = {{(data_w - 2){1'b0}}, half_res, boot_mode};
            reg_pending:
                rd_data = data_w'(pending.vec);
            reg_mask:
                rd_data = data_w'(mask.vec);
            reg_active:
                // Valid flag in bit 7, index in the low bits
                rd_data = data_w'({active_valid, 4'b0000, active_idx});
            reg_led:
                rd_data = data_w'(led_q);
            default:
                addr_ok = 1'b0;
        endcase
    end

    // Unmapped offsets read zero
    assign prdata  = rd_data;
    assign pslverr = access & ~addr_ok;

    // Mask and LED registers, STATUS and ACTIVE ignore writes
    always_ff @(posedge clk100)
    begin
        if (sys_rst)
        begin
            mask  <= '0;
            led_q <= '0;
        end
        else if (wr_en)
        begin
            if (paddr == reg_mask)
                mask.vec <= pwdata[irq_w-1:0];
            if (paddr == reg_led)
                led_q <= pwdata[led_w-1:0];
        end
    end

    // Write-1-to-clear, lands in pending at the end of the access cycle
    assign clear_req.vec = (wr_en && paddr == reg_pending) ? pwdata[irq_w-1:0] : '0;

    // LED order from bit 0
    assign led_gpu   = led_q[0];
    assign led_flash = led_q[1];
    assign led_usb   = led_q[2];
    assign led_eth   = led_q[3];
    assign led_user  = led_q[4];

    a_penable_needs_psel: assert property (@(posedge clk100) disable iff (sys_rst)
        penable |-> psel)
        else $error("penable without psel");

endmodule

//--- board_ctrl_top.sv
`timescale 1ns/1ns

module board_ctrl_top #(
    parameter int DTR_RESET_CYCLES = 16
) (
    input  logic                         clk100,
    input  logic                         rst,
    input  logic                         uart_dtr_n,
    input  logic                         reset_n,
    input  logic [3:0]                   dipsw,
    input  logic                         frame_drawn,
    input  logic                         uart_irq,
    input  logic                         ost1_int,
    input  logic                         ost2_int,
    input  logic                         ost3_int,
    input  logic                         uart_rx,
    input  logic                         uart_tx_mon,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [board_pkg::addr_w-1:0] paddr,
    input  logic [board_pkg::data_w-1:0] pwdata,
    output logic [board_pkg::data_w-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         cpu_rst,
    output board_pkg::irq_word_t         irq_vec,
    output logic                         irq,
    output logic                         led_gpu,
    output logic                         led_flash,
    output logic                         led_usb,
    output logic                         led_eth,
    output logic                         led_user,
    output logic                         led_uart_rx,
    output logic                         led_uart_tx
);

    import board_pkg::*;

    logic       sys_rst;
    logic       boot_mode;
    logic       half_res;
    logic       frame_pulse;
    logic       active_valid;
    logic [2:0] active_idx;
    irq_word_t  pending;
    irq_word_t  mask;
    irq_word_t  clear_req;

    // Reset from button, DTR and system reset
    reset_gen #(
        .DTR_RESET_CYCLES(DTR_RESET_CYCLES)
    ) u_reset_gen (
        .clk100(clk100), .rst(rst), .reset_n(reset_n), .uart_dtr_n(uart_dtr_n),
        .cpu_rst(cpu_rst), .sys_rst(sys_rst)
    );

    board_inputs u_board_inputs (
        .clk100(clk100), .sys_rst(sys_rst), .dipsw(dipsw), .frame_drawn(frame_drawn),
        .boot_mode(boot_mode), .half_res(half_res), .frame_pulse(frame_pulse)
    );

    irq_ctrl u_irq_ctrl (
        .clk100(clk100), .sys_rst(sys_rst),
        .uart_irq(uart_irq), .ost1_int(ost1_int), .ost2_int(ost2_int),
        .ost3_int(ost3_int), .frame_pulse(frame_pulse),
        .mask(mask), .clear_req(clear_req), .pending(pending), .irq_vec(irq_vec),
        .irq(irq), .active_valid(active_valid), .active_idx(active_idx)
    );

    apb_regs u_apb_regs (
        .clk100(clk100), .sys_rst(sys_rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .boot_mode(boot_mode), .half_res(half_res), .pending(pending),
        .active_valid(active_valid), .active_idx(active_idx),
        .mask(mask), .clear_req(clear_req),
        .led_gpu(led_gpu), .led_flash(led_flash), .led_usb(led_usb),
        .led_eth(led_eth), .led_user(led_user)
    );

    // UART lines idle high, so the LEDs light on activity
    assign led_uart_rx = ~uart_rx;
    assign led_uart_tx = ~uart_tx_mon;

endmodule

//--- tb_board_ctrl.sv
`timescale 1ns/1ns

module tb_board_ctrl;

    import board_pkg::*;

    localparam int dtr_cycles = 16;

    // One row of the stimulus table
    typedef struct {
        string             name;
        logic [3:0]        dsw;
        irq_word_t         src;
        logic              wr;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] rdata;
        logic              err;
        logic              irq;
        irq_word_t         vec;
        logic [led_w-1:0]  led;
    } entry_t;

    logic              clk100;
    logic              rst;
    logic              uart_dtr_n;
    logic              reset_n;
    logic [3:0]        dipsw;
    logic              frame_drawn;
    logic              uart_irq;
    logic              ost1_int;
    logic              ost2_int;
    logic              ost3_int;
    logic              uart_rx;
    logic              uart_tx_mon;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              cpu_rst;
    irq_word_t         irq_vec;
    logic              irq;
    logic              led_gpu;
    logic              led_flash;
    logic              led_usb;
    logic              led_eth;
    logic              led_user;
    logic              led_uart_rx;
    logic              led_uart_tx;

    entry_t tbl[$];
    bit     table_ready;
    int     split;
    int     err_count;
    int     pass_count;
    int     fail_count;

    board_ctrl_top #(
        .DTR_RESET_CYCLES(dtr_cycles)
    ) dut (.*);

    always #20 clk100 = ~clk100;

    task automatic check_word(input string name, input string what,
                              input logic [data_w-1:0] exp, input logic [data_w-1:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_irq(input string name, input irq_word_t exp, input irq_word_t act);
        if (act.vec !== exp.vec)
        begin
            $display("FAILED %s irq_vec: expected %h, actual %h", name, exp.vec, act.vec);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAILED %s %s: expected %b, actual %b", name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("done %s: ok", name);
            pass_count++;
        end
        else
        begin
            $display("done %s: %0d mismatch(es)", name, err_count - errs_before);
            fail_count++;
        end
    endtask

    task automatic add_entry(input string name, input int dsw, input int src, input int wr,
                             input int addr, input int wdata, input int rdata, input int err,
                             input int irq_e, input int vec, input int led);
        entry_t e;
        e.name    = name;
        e.dsw     = dsw[3:0];
        e.src.vec = src[irq_w-1:0];
        e.wr      = wr[0];
        e.addr    = addr[addr_w-1:0];
        e.wdata   = wdata;
        e.rdata   = rdata;
        e.err     = err[0];
        e.irq     = irq_e[0];
        e.vec.vec = vec[irq_w-1:0];
        e.led     = led[led_w-1:0];
        tbl.push_back(e);
    endtask

    // Caller sits on a falling edge, returns on the falling edge after the access
    task automatic apb_xfer(input logic wr, input logic [addr_w-1:0] addr,
                            input logic [data_w-1:0] wdata,
                            output logic [data_w-1:0] rdata, output logic err);
        // Setup cycle
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk100);
        penable = 1'b1;
        #1;
        // No wait states, so pready is due in the first access cycle
        if (pready !== 1'b1)
        begin
            $display("pready low in the APB access cycle at offset %h", addr);
            err_count++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk100);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apply_entry(input int idx);
        entry_t            e;
        int                errs_before;
        logic [data_w-1:0] rdata;
        logic              err;
        e           = tbl[idx];
        errs_before = err_count;
        @(negedge clk100);
        dipsw       = e.dsw;
        uart_irq    = e.src.fld.uart;
        ost1_int    = e.src.fld.ost1;
        ost2_int    = e.src.fld.ost2;
        ost3_int    = e.src.fld.ost3;
        frame_drawn = e.src.fld.frame;
        // Level sources for one cycle, frame-drawn for four
        @(negedge clk100);
        {uart_irq, ost1_int, ost2_int, ost3_int} = 4'b0000;
        if (e.src.fld.frame)
            repeat (3) @(negedge clk100);
        frame_drawn = 1'b0;
        repeat (6) @(negedge clk100);
        apb_xfer(e.wr, e.addr, e.wdata, rdata, err);
        if (!e.wr)
            check_word(e.name, "prdata", e.rdata, rdata);
        check_bit(e.name, "pslverr", e.err, err);
        check_bit(e.name, "irq", e.irq, irq);
        check_irq(e.name, e.vec, irq_vec);
        check_word(e.name, "leds", data_w'(e.led),
                   data_w'({led_user, led_eth, led_usb, led_flash, led_gpu}));
        report(e.name, errs_before);
    endtask

    task automatic dtr_test();
        int errs_before;
        int waited;
        int high_cycles;
        errs_before = err_count;
        waited      = 0;
        high_cycles = 0;
        @(negedge clk100);
        uart_dtr_n = 1'b0;
        // Edge passes the synchronizer first
        while (!cpu_rst && waited < 10)
        begin
            @(negedge clk100);
            waited++;
        end
        check_bit("dtr_reset", "start 3 to 4 cycles after edge", 1'b1,
                  waited >= 3 && waited <= 4);
        while (cpu_rst && high_cycles < dtr_cycles + 10)
        begin
            high_cycles++;
            @(negedge clk100);
        end
        uart_dtr_n = 1'b1;
        check_word("dtr_reset", "cpu_rst cycles", 32'(dtr_cycles), 32'(high_cycles));
        report("dtr_reset", errs_before);
    endtask

    task automatic uart_led_test();
        int errs_before;
        errs_before = err_count;
        @(negedge clk100);
        uart_rx     = 1'b0;
        uart_tx_mon = 1'b1;
        #1;
        check_bit("uart_leds", "led_uart_rx", 1'b1, led_uart_rx);
        check_bit("uart_leds", "led_uart_tx", 1'b0, led_uart_tx);
        @(negedge clk100);
        uart_rx     = 1'b1;
        uart_tx_mon = 1'b0;
        #1;
        check_bit("uart_leds", "led_uart_rx", 1'b0, led_uart_rx);
        check_bit("uart_leds", "led_uart_tx", 1'b1, led_uart_tx);
        report("uart_leds", errs_before);
    endtask

    initial
    begin : main
        logic [31:0] r;
        clk100      = 1'b0;
        rst         = 1'b1;
        {uart_dtr_n, reset_n, uart_rx, uart_tx_mon} = 4'b1111;
        dipsw       = 4'h0;
        frame_drawn = 1'b0;
        {uart_irq, ost1_int, ost2_int, ost3_int} = 4'b0000;
        {psel, penable, pwrite} = 3'b000;
        paddr       = '0;
        pwdata      = '0;
        void'($urandom(32'h2d53_34e7));

        // name, dipsw, sources, write, offset, wdata, rdata, pslverr, irq, irq_vec, leds
        add_entry("status_sw3", 'h8, 0, 0, reg_status, 0, 'h1, 0, 0, 0, 0);
        add_entry("status_sw2", 'h4, 0, 0, reg_status, 0, 'h2, 0, 0, 0, 0);
        for (int k = 0; k < 3; k++)
        begin
            r = $urandom;
            // Switch 3 lands in bit 0, switch 2 in bit 1
            add_entry($sformatf("status_rand%0d", k), r[3:0], 0, 0, reg_status, 0,
                      {r[2], r[3]}, 0, 0, 0, 0);
        end
        add_entry("status_wr", 'hC, 0, 1, reg_status, -1, 0, 0, 0, 0, 0);
        add_entry("status_rd", 'hC, 0, 0, reg_status, 0, 'h3, 0, 0, 0, 0);
        add_entry("unmap_rd_14", 0, 0, 0, 'h14, 0, 0, 1, 0, 0, 0);
        add_entry("unmap_wr_1c", 0, 0, 1, 'h1C, -1, 0, 1, 0, 0, 0);
        add_entry("unmap_rd_02", 0, 0, 0, 'h02, 0, 0, 1, 0, 0, 0);
        add_entry("mask_idle", 0, 0, 0, reg_mask, 0, 0, 0, 0, 0, 0);
        // Masked-off sources latch without raising irq
        add_entry("src_pulse", 0, 'h05, 0, reg_pending, 0, 'h05, 0, 0, 0, 0);
        add_entry("mask_wr", 0, 0, 1, reg_mask, 'h05, 0, 0, 1, 'h05, 0);
        add_entry("mask_rd", 0, 0, 0, reg_mask, 0, 'h05, 0, 1, 'h05, 0);
        add_entry("active_uart", 0, 0, 0, reg_active, 0, 'h80, 0, 1, 'h05, 0);
        add_entry("clr_uart", 0, 0, 1, reg_pending, 'h01, 0, 0, 1, 'h04, 0);
        add_entry("active_ost2", 0, 0, 0, reg_active, 0, 'h82, 0, 1, 'h04, 0);
        // Frame bit stays masked, vector unchanged
        add_entry("frame_set", 0, 'h10, 0, reg_pending, 0, 'h14, 0, 1, 'h04, 0);
        add_entry("clr_zero", 0, 0, 1, reg_pending, 0, 0, 0, 1, 'h04, 0);
        add_entry("pend_kept", 0, 0, 0, reg_pending, 0, 'h14, 0, 1, 'h04, 0);
        add_entry("clr_frame", 0, 0, 1, reg_pending, 'h10, 0, 0, 1, 'h04, 0);
        add_entry("pend_frame_gone", 0, 0, 0, reg_pending, 0, 'h04, 0, 1, 'h04, 0);
        add_entry("led_wr", 0, 0, 1, reg_led, 'h15, 0, 0, 1, 'h04, 'h15);
        add_entry("led_rd", 0, 0, 0, reg_led, 0, 'h15, 0, 1, 'h04, 'h15);
        add_entry("led_wr2", 0, 0, 1, reg_led, 'h0A, 0, 0, 1, 'h04, 'h0A);
        split = tbl.size();
        // After the DTR reset everything reads back clear
        add_entry("post_mask", 0, 0, 0, reg_mask, 0, 0, 0, 0, 0, 0);
        add_entry("post_pending", 0, 0, 0, reg_pending, 0, 0, 0, 0, 0, 0);
        add_entry("post_led", 0, 0, 0, reg_led, 0, 0, 0, 0, 0, 0);
        table_ready = 1'b1;

        repeat (5) @(posedge clk100);
        @(negedge clk100);
        rst = 1'b0;

        for (int i = 0; i < split; i++)
            apply_entry(i);
        dtr_test();
        for (int i = split; i < tbl.size(); i++)
            apply_entry(i);
        uart_led_test();

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Budget of 30 cycles per table row plus slack
    initial
    begin : watchdog
        wait (table_ready);
        #(tbl.size() * 30 * 40 + 2000);
        $display("Timeout: the run did not finish within its time budget");
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- vlog.f
board_pkg.sv
reset_gen.sv
board_inputs.sv
irq_ctrl.sv
apb_regs.sv
board_ctrl_top.sv
tb_board_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_board_ctrl
FILELIST  = vlog.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJDIR)
